// File: rtl/rv32i_pkg.sv
package rv32i_pkg;

    // --------------------
    // Widths and reset
    // --------------------
    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam logic [XLEN-1:0] RESET_PC = '0;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // --------------------
    // Major opcodes
    // --------------------
    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LUI = 7'b0110111;
    localparam logic [6:0] OP_LOAD = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL = 7'b1101111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_t;

    // All zero means bubble
    typedef struct packed {
        logic alu_src;
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic branch;
        logic jal;
        logic lui;
    } ctrl_t;

    // --------------------
    // Stage payloads
    // --------------------
    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        word_t pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t imm;
        word_t rs1_data;
        word_t rs2_data;
        logic [2:0] funct3;
        alu_op_t alu_op;
        ctrl_t ctrl;
    } id_ex_t;

    typedef struct packed {
        word_t alu_result;
        word_t store_data;
        reg_addr_t rd;
        ctrl_t ctrl;
    } ex_mem_t;

    typedef struct packed {
        word_t data;
        reg_addr_t rd;
        logic reg_write;
    } mem_wb_t;

    // Data memory request
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic read_en;
        logic write_en;
    } dmem_req_t;

    // Register file write port
    typedef struct packed {
        logic en;
        reg_addr_t addr;
        word_t data;
    } wb_t;

endpackage

// File: rtl/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     en,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // Zero payload is a bubble, flush beats enable
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (en) begin
            q <= d;
        end
    end

endmodule

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import rv32i_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   pc_en,
    input  logic   redirect,
    input  word_t  redirect_pc,
    output word_t  imem_addr,
    input  word_t  imem_data,
    output if_id_t if_id
);

    word_t pc;
    word_t next_pc;

    // Redirect from execute wins over sequential fetch
    assign next_pc = redirect ? redirect_pc : pc + word_t'(4);

    // PC register, held while stalled
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (pc_en) begin
            pc <= next_pc;
        end
    end

    // Instruction memory answers in the same cycle
    assign imem_addr = pc;

    assign if_id.pc = pc;
    assign if_id.instr = imem_data;

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  if_id_t    if_id,
    input  wb_t       wb,
    output id_ex_t    id_ex,
    output reg_addr_t rs1,
    output reg_addr_t rs2
);

    // --------------------
    // Instruction fields
    // --------------------
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t rd;
    word_t instr;
    word_t imm;
    ctrl_t ctrl;
    alu_op_t alu_op;
    logic use_rs1;
    logic use_rs2;

    // x0 lives outside the array
    word_t regs [1:31];

    assign instr = if_id.instr;
    assign opcode = instr[6:0];
    assign rd = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Same mapping for register and immediate forms, SUB only with registers
    function automatic alu_op_t decode_alu(input logic [2:0] f3, input logic alt,
                                           input logic is_reg);
        alu_op_t op;
        case (f3)
            3'b000: op = (is_reg && alt) ? ALU_SUB : ALU_ADD;
            3'b001: op = ALU_SLL;
            3'b010: op = ALU_SLT;
            3'b011: op = ALU_SLTU;
            3'b100: op = ALU_XOR;
            3'b101: op = alt ? ALU_SRA : ALU_SRL;
            3'b110: op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // --------------------
    // Control and immediates
    // --------------------
    always_comb begin
        ctrl = '0;
        imm = '0;
        alu_op = ALU_ADD;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            OP_REG: begin
                ctrl.reg_write = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                alu_op = decode_alu(funct3, funct7[5], 1'b1);
            end
            OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src = 1'b1;
                use_rs1 = 1'b1;
                imm = {{20{instr[31]}}, instr[31:20]};
                alu_op = decode_alu(funct3, funct7[5], 1'b0);
            end
            OP_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.lui = 1'b1;
                imm = {instr[31:12], 12'b0};
            end
            OP_LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src = 1'b1;
                ctrl.mem_read = 1'b1;
                use_rs1 = 1'b1;
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            OP_STORE: begin
                ctrl.alu_src = 1'b1;
                ctrl.mem_write = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OP_BRANCH: begin
                ctrl.branch = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OP_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jal = 1'b1;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            // Unknown opcode stays a bubble
            default: ctrl = '0;
        endcase
        // Writes to x0 are dropped here
        if (rd == '0) begin
            ctrl.reg_write = 1'b0;
        end
    end

    // Unused sources read as x0, no false hazards
    assign rs1 = use_rs1 ? instr[19:15] : '0;
    assign rs2 = use_rs2 ? instr[24:20] : '0;

    // --------------------
    // Register file
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // Write-through so WB and ID can share a cycle
    function automatic word_t read_reg(input reg_addr_t a);
        word_t val;
        if (a == '0) begin
            val = '0;
        end else if (wb.en && wb.addr == a) begin
            val = wb.data;
        end else begin
            val = regs[a];
        end
        return val;
    endfunction

    assign id_ex.pc = if_id.pc;
    assign id_ex.rs1 = rs1;
    assign id_ex.rs2 = rs2;
    assign id_ex.rd = rd;
    assign id_ex.imm = imm;
    assign id_ex.rs1_data = read_reg(rs1);
    assign id_ex.rs2_data = read_reg(rs2);
    assign id_ex.funct3 = funct3;
    assign id_ex.alu_op = alu_op;
    assign id_ex.ctrl = ctrl;

endmodule

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import rv32i_pkg::*; (
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t ex_rd,
    input  logic      ex_mem_read,
    input  logic      redirect,
    output logic      pc_en,
    output logic      if_id_en,
    output logic      if_id_flush,
    output logic      id_ex_flush
);

    logic load_use;

    // Load in execute feeding the instruction in decode
    assign load_use = ex_mem_read && (ex_rd != '0) && ((ex_rd == rs1) || (ex_rd == rs2));

    // Redirect overrides the stall
    assign pc_en = !load_use || redirect;
    assign if_id_en = !load_use;

    // Squash the two younger instructions on redirect
    assign if_id_flush = redirect;
    // Bubble into execute on stall too
    assign id_ex_flush = redirect || load_use;

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import rv32i_pkg::*; (
    input  id_ex_t    id_ex,
    input  reg_addr_t mem_rd,
    input  logic      mem_reg_write,
    input  word_t     fwd_mem,
    input  wb_t       wb,
    output ex_mem_t   ex_mem,
    output logic      redirect,
    output word_t     redirect_pc
);

    word_t src_a;
    word_t src_b;
    word_t op_a;
    word_t op_b;
    word_t alu_out;
    logic taken;

    // --------------------
    // Forwarding
    // --------------------
    // MEM is younger than WB so it wins
    function automatic word_t fwd_sel(input reg_addr_t rs, input word_t reg_val);
        word_t val;
        if (rs != '0 && mem_reg_write && mem_rd == rs) begin
            val = fwd_mem;
        end else if (rs != '0 && wb.en && wb.addr == rs) begin
            val = wb.data;
        end else begin
            val = reg_val;
        end
        return val;
    endfunction

    assign src_a = fwd_sel(id_ex.rs1, id_ex.rs1_data);
    assign src_b = fwd_sel(id_ex.rs2, id_ex.rs2_data);

    // LUI is zero plus immediate
    assign op_a = id_ex.ctrl.lui ? '0 : src_a;
    assign op_b = (id_ex.ctrl.alu_src || id_ex.ctrl.lui) ? id_ex.imm : src_b;

    // --------------------
    // ALU
    // --------------------
    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_AND:  alu_out = op_a & op_b;
            ALU_OR:   alu_out = op_a | op_b;
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_SLT:  alu_out = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_out = word_t'(op_a < op_b);
            ALU_SLL:  alu_out = op_a << op_b[4:0];
            ALU_SRL:  alu_out = op_a >> op_b[4:0];
            ALU_SRA:  alu_out = word_t'($signed(op_a) >>> op_b[4:0]);
            default:  alu_out = op_a + op_b;
        endcase
    end

    // --------------------
    // Branch resolution
    // --------------------
    // Compare on forwarded registers, not ALU flags
    always_comb begin
        case (id_ex.funct3)
            3'b000:  taken = (src_a == src_b);
            3'b001:  taken = (src_a != src_b);
            3'b100:  taken = ($signed(src_a) < $signed(src_b));
            3'b101:  taken = ($signed(src_a) >= $signed(src_b));
            3'b110:  taken = (src_a < src_b);
            3'b111:  taken = (src_a >= src_b);
            default: taken = 1'b0;
        endcase
    end

    assign redirect = id_ex.ctrl.jal || (id_ex.ctrl.branch && taken);
    assign redirect_pc = id_ex.pc + id_ex.imm;

    // JAL links PC+4
    assign ex_mem.alu_result = id_ex.ctrl.jal ? id_ex.pc + word_t'(4) : alu_out;
    assign ex_mem.store_data = src_b;
    assign ex_mem.rd = id_ex.rd;
    assign ex_mem.ctrl = id_ex.ctrl;

endmodule

// File: rtl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import rv32i_pkg::*; (
    input  ex_mem_t   ex_mem,
    output dmem_req_t dmem_req,
    input  word_t     dmem_rdata,
    output word_t     fwd_mem,
    output mem_wb_t   mem_wb
);

    // Word access straight from the EX/MEM payload
    assign dmem_req.addr = ex_mem.alu_result;
    assign dmem_req.wdata = ex_mem.store_data;
    assign dmem_req.read_en = ex_mem.ctrl.mem_read;
    assign dmem_req.write_en = ex_mem.ctrl.mem_write;

    // Load data is not ready for forwarding from here
    assign fwd_mem = ex_mem.alu_result;

    // Writeback value picked before MEM/WB
    assign mem_wb.data = ex_mem.ctrl.mem_read ? dmem_rdata : ex_mem.alu_result;
    assign mem_wb.rd = ex_mem.rd;
    assign mem_wb.reg_write = ex_mem.ctrl.reg_write;

endmodule

// File: rtl/rv32i_core.sv
`timescale 1ns/1ps

module rv32i_core import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    output word_t     imem_addr,
    input  word_t     imem_data,
    output dmem_req_t dmem_req,
    input  word_t     dmem_rdata,
    output wb_t       wb
);

    // --------------------
    // Stage payloads
    // --------------------
    if_id_t if_id_d;
    if_id_t if_id_q;
    id_ex_t id_ex_d;
    id_ex_t id_ex_q;
    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    mem_wb_t mem_wb_d;
    mem_wb_t mem_wb_q;

    // Hazard and redirect
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic pc_en;
    logic if_id_en;
    logic if_id_flush;
    logic id_ex_flush;
    logic redirect;
    word_t redirect_pc;
    word_t fwd_mem;

    // Fetch
    fetch_stage u_fetch (
        .clk        (clk),
        .arst_n     (arst_n),
        .pc_en      (pc_en),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .if_id      (if_id_d)
    );

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk   (clk),
        .arst_n(arst_n),
        .en    (if_id_en),
        .flush (if_id_flush),
        .d     (if_id_d),
        .q     (if_id_q)
    );

    // Decode and register file
    decode_stage u_decode (
        .clk   (clk),
        .arst_n(arst_n),
        .if_id (if_id_q),
        .wb    (wb),
        .id_ex (id_ex_d),
        .rs1   (rs1),
        .rs2   (rs2)
    );

    hazard_unit u_hazard (
        .rs1        (rs1),
        .rs2        (rs2),
        .ex_rd      (id_ex_q.rd),
        .ex_mem_read(id_ex_q.ctrl.mem_read),
        .redirect   (redirect),
        .pc_en      (pc_en),
        .if_id_en   (if_id_en),
        .if_id_flush(if_id_flush),
        .id_ex_flush(id_ex_flush)
    );

    // ID/EX has no hold, stalls insert bubbles
    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk   (clk),
        .arst_n(arst_n),
        .en    (1'b1),
        .flush (id_ex_flush),
        .d     (id_ex_d),
        .q     (id_ex_q)
    );

    // Execute
    execute_stage u_execute (
        .id_ex        (id_ex_q),
        .mem_rd       (ex_mem_q.rd),
        .mem_reg_write(ex_mem_q.ctrl.reg_write),
        .fwd_mem      (fwd_mem),
        .wb           (wb),
        .ex_mem       (ex_mem_d),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk   (clk),
        .arst_n(arst_n),
        .en    (1'b1),
        .flush (1'b0),
        .d     (ex_mem_d),
        .q     (ex_mem_q)
    );

    // Memory
    memory_stage u_memory (
        .ex_mem    (ex_mem_q),
        .dmem_req  (dmem_req),
        .dmem_rdata(dmem_rdata),
        .fwd_mem   (fwd_mem),
        .mem_wb    (mem_wb_d)
    );

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk   (clk),
        .arst_n(arst_n),
        .en    (1'b1),
        .flush (1'b0),
        .d     (mem_wb_d),
        .q     (mem_wb_q)
    );

    // Writeback is just the MEM/WB payload
    assign wb.en = mem_wb_q.reg_write;
    assign wb.addr = mem_wb_q.rd;
    assign wb.data = mem_wb_q.data;

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD_NS = 5
) (
    output logic clk
);

    // Free running, first rising edge at 5 ns
    initial clk = 1'b0;

    always #(HALF_PERIOD_NS) clk = ~clk;

endmodule

// File: tests/rv32i_core_props.sv
`timescale 1ns/1ps

module rv32i_core_props import rv32i_pkg::*; (
    input logic      clk,
    input logic      arst_n,
    input word_t     imem_addr,
    input dmem_req_t dmem_req,
    input wb_t       wb
);

    // x0 writes are dropped in decode
    a_wb_addr_nonzero: assert property (
        @(posedge clk) disable iff (!arst_n) wb.en |-> (wb.addr != '0)
    ) else $error("Register write to x0 on the writeback port");

    // One data access per cycle
    a_dmem_one_access: assert property (
        @(posedge clk) disable iff (!arst_n) !(dmem_req.read_en && dmem_req.write_en)
    ) else $error("Data memory read and write enabled together");

    // Word accesses only
    a_dmem_aligned: assert property (
        @(posedge clk) disable iff (!arst_n)
        (dmem_req.read_en || dmem_req.write_en) |-> (dmem_req.addr[1:0] == 2'b00)
    ) else $error("Unaligned data memory address %h", dmem_req.addr);

    a_imem_aligned: assert property (
        @(posedge clk) disable iff (!arst_n) imem_addr[1:0] == 2'b00
    ) else $error("Unaligned fetch address %h", imem_addr);

endmodule

bind rv32i_core rv32i_core_props u_props (
    .clk      (clk),
    .arst_n   (arst_n),
    .imem_addr(imem_addr),
    .dmem_req (dmem_req),
    .wb       (wb)
);

// File: tests/tb_rv32i_core.sv
`timescale 1ns/1ps

module tb_rv32i_core import rv32i_pkg::*; ();

    // --------------------
    // Test sizes
    // --------------------
    localparam int NUM_PROGS = 20;
    localparam int RESET_CYCLES = 8;
    localparam int SEED_REGS = 6;
    localparam int BODY_LEN = 48;
    // LUI and ADDI per seeded register, body, final loop
    localparam int PROG_LEN = 2 * SEED_REGS + BODY_LEN + 1;
    localparam int LAST_IDX = PROG_LEN - 1;
    localparam word_t LOOP_PC = LAST_IDX * 4;
    localparam int DRAIN_CYCLES = 6;
    // Reset plus at most three cycles per instruction, small margin per program
    localparam int CYCLE_LIMIT = NUM_PROGS * (RESET_CYCLES + 3 * PROG_LEN + 9);
    localparam word_t NOP = 32'h0000_0013;

    // Instruction kinds of the generator
    localparam logic [2:0] K_REG = 3'd0;
    localparam logic [2:0] K_IMM = 3'd1;
    localparam logic [2:0] K_LUI = 3'd2;
    localparam logic [2:0] K_LW = 3'd3;
    localparam logic [2:0] K_SW = 3'd4;
    localparam logic [2:0] K_BR = 3'd5;
    localparam logic [2:0] K_JAL = 3'd6;

    // One generated instruction
    typedef struct packed {
        logic [2:0] kind;
        logic [2:0] f3;
        logic alt;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t imm;
    } insn_t;

    logic clk;
    logic arst_n;
    word_t imem_addr;
    word_t imem_data;
    dmem_req_t dmem_req;
    word_t dmem_rdata;
    wb_t wb;

    // Memories seen by the DUT
    word_t imem [0:127];
    word_t dmem [0:63];

    // Reference model state
    insn_t prog [0:PROG_LEN-1];
    word_t m_regs [0:31];
    word_t m_mem [0:63];

    // Expected register writes, loads and stores, in program order
    reg_addr_t exp_rd [$];
    word_t exp_data [$];
    word_t exp_ld_addr [$];
    word_t exp_st_addr [$];
    word_t exp_st_data [$];

    integer seed;
    int wb_errors;
    int ld_errors;
    int st_errors;
    int other_errors;
    int cycles = 0;

    tb_clock u_clock (
        .clk(clk)
    );

    rv32i_core u_rv32i_core (
        .clk       (clk),
        .arst_n    (arst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .dmem_req  (dmem_req),
        .dmem_rdata(dmem_rdata),
        .wb        (wb)
    );

    // Both memories answer in the same cycle, quiet during reset
    assign imem_data = arst_n ? imem[imem_addr[8:2]] : NOP;
    assign dmem_rdata = arst_n ? dmem[dmem_req.addr[7:2]] : '0;

    // --------------------
    // Helpers
    // --------------------
    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    // Initial data word from its byte address
    function automatic word_t fill_word(input int i);
        logic [7:0] a;
        a = {i[5:0], 2'b00};
        return {a ^ 8'h3c, ~a, a, 8'ha5};
    endfunction

    function automatic word_t encode(input insn_t ins);
        word_t w;
        case (ins.kind)
            K_REG: w = {1'b0, ins.alt, 5'b0, ins.rs2, ins.rs1, ins.f3, ins.rd, OP_REG};
            K_IMM: w = {ins.imm[11:0], ins.rs1, ins.f3, ins.rd, OP_IMM};
            K_LUI: w = {ins.imm[31:12], ins.rd, OP_LUI};
            K_LW: w = {ins.imm[11:0], 5'd0, 3'b010, ins.rd, OP_LOAD};
            K_SW: w = {ins.imm[11:5], ins.rs2, 5'd0, 3'b010, ins.imm[4:0], OP_STORE};
            K_BR: w = {ins.imm[12], ins.imm[10:5], ins.rs2, ins.rs1, ins.f3,
                       ins.imm[4:1], ins.imm[11], OP_BRANCH};
            default: w = {ins.imm[20], ins.imm[10:1], ins.imm[11], ins.imm[19:12],
                          ins.rd, OP_JAL};
        endcase
        return w;
    endfunction

    // RV32I integer semantics by funct3
    function automatic word_t model_alu(input logic [2:0] f3, input logic alt,
                                        input logic is_reg, input word_t a, input word_t b);
        word_t r;
        case (f3)
            3'd0: r = (is_reg && alt) ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = {31'b0, $signed(a) < $signed(b)};
            3'd3: r = {31'b0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input word_t a,
                                          input word_t b);
        logic t;
        case (f3)
            3'd0: t = (a == b);
            3'd1: t = (a != b);
            3'd4: t = ($signed(a) < $signed(b));
            3'd5: t = ($signed(a) >= $signed(b));
            3'd6: t = (a < b);
            3'd7: t = (a >= b);
            default: t = 1'b0;
        endcase
        return t;
    endfunction

    // --------------------
    // Program generator
    // --------------------
    task automatic gen_program;
        insn_t ins;
        word_t rnd;
        word_t val;
        int idx;
        int off_w;
        logic [3:0] kind_sel;
        idx = 0;
        // Opening run seeds x1..x6
        for (int r = 1; r <= SEED_REGS; r++) begin
            rnd = rand_word();
            ins = '0;
            ins.kind = K_LUI;
            ins.rd = r[4:0];
            ins.imm = {rnd[31:12], 12'b0};
            prog[idx] = ins;
            ins.kind = K_IMM;
            ins.rs1 = r[4:0];
            ins.imm = {{20{rnd[11]}}, rnd[11:0]};
            prog[idx + 1] = ins;
            idx = idx + 2;
        end
        for (int i = 0; i < BODY_LEN; i++) begin
            rnd = rand_word();
            val = rand_word();
            ins = '0;
            // Only x0..x7 so dependences are frequent
            ins.rd = {2'b00, rnd[2:0]};
            ins.rs1 = {2'b00, rnd[5:3]};
            ins.rs2 = {2'b00, rnd[8:6]};
            ins.f3 = rnd[11:9];
            kind_sel = rnd[15:12];
            off_w = (rnd[17:16] == 2'd2) ? 4 : ((rnd[17:16] == 2'd1) ? 3 : 2);
            // Jump past the final loop turns into an ALU op
            if (kind_sel >= 4'd13 && idx + off_w > LAST_IDX) begin
                kind_sel = 4'd0;
            end
            if (kind_sel < 4'd5) begin
                ins.kind = K_REG;
                ins.alt = (ins.f3 == 3'd0 || ins.f3 == 3'd5) ? rnd[18] : 1'b0;
            end else if (kind_sel < 4'd8) begin
                ins.kind = K_IMM;
                if (ins.f3 == 3'd1 || ins.f3 == 3'd5) begin
                    // Shift amount, bit 10 picks SRAI
                    ins.alt = (ins.f3 == 3'd5) ? rnd[18] : 1'b0;
                    ins.imm = {21'b0, ins.alt, 5'b0, val[4:0]};
                end else begin
                    ins.imm = {{20{val[11]}}, val[11:0]};
                end
            end else if (kind_sel == 4'd8) begin
                ins.kind = K_LUI;
                ins.imm = {val[31:12], 12'b0};
            end else if (kind_sel < 4'd11) begin
                ins.kind = K_LW;
                ins.rs1 = '0;
                ins.imm = {24'b0, val[5:0], 2'b00};
            end else if (kind_sel < 4'd13) begin
                ins.kind = K_SW;
                ins.rs1 = '0;
                ins.imm = {24'b0, val[5:0], 2'b00};
            end else if (kind_sel < 4'd15) begin
                ins.kind = K_BR;
                // funct3 2 and 3 folded onto BLTU and BGEU
                if (ins.f3[2:1] == 2'b01) begin
                    ins.f3 = {2'b11, ins.f3[0]};
                end
                ins.imm = off_w * 4;
            end else begin
                ins.kind = K_JAL;
                ins.imm = off_w * 4;
            end
            prog[idx] = ins;
            idx++;
        end
        // JAL x0 to itself
        ins = '0;
        ins.kind = K_JAL;
        prog[idx] = ins;
        for (int i = 0; i < 128; i++) begin
            imem[i] = NOP;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            imem[i] = encode(prog[i]);
        end
    endtask

    // --------------------
    // Reference model
    // --------------------
    task automatic run_model;
        insn_t ins;
        word_t a;
        word_t b;
        word_t val;
        logic wr;
        int idx;
        int next;
        idx = 0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            m_mem[i] = fill_word(i);
        end
        // Forward jumps only, so this always reaches the loop
        while (idx != LAST_IDX) begin
            ins = prog[idx];
            a = m_regs[ins.rs1];
            b = m_regs[ins.rs2];
            next = idx + 1;
            wr = 1'b1;
            val = '0;
            case (ins.kind)
                K_REG: val = model_alu(ins.f3, ins.alt, 1'b1, a, b);
                K_IMM: val = model_alu(ins.f3, ins.alt, 1'b0, a, ins.imm);
                K_LUI: val = ins.imm;
                K_LW: begin
                    // Read happens even when rd is x0
                    val = m_mem[ins.imm[7:2]];
                    exp_ld_addr.push_back(ins.imm);
                end
                K_SW: begin
                    wr = 1'b0;
                    m_mem[ins.imm[7:2]] = b;
                    exp_st_addr.push_back(ins.imm);
                    exp_st_data.push_back(b);
                end
                K_BR: begin
                    wr = 1'b0;
                    if (branch_taken(ins.f3, a, b)) begin
                        next = idx + ins.imm[4:2];
                    end
                end
                default: begin
                    // JAL links the next PC
                    val = idx * 4 + 4;
                    next = idx + ins.imm[4:2];
                end
            endcase
            if (wr && ins.rd != '0) begin
                m_regs[ins.rd] = val;
                exp_rd.push_back(ins.rd);
                exp_data.push_back(val);
            end
            idx = next;
        end
    endtask

    // Retire everything, reach the loop, then watch for stray writes
    task automatic wait_retire;
        while (exp_rd.size() != 0 || exp_st_addr.size() != 0 || exp_ld_addr.size() != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
        // The self-loop fetches LOOP_PC and the two words after it
        while (imem_addr < LOOP_PC || imem_addr > LOOP_PC + 8) begin
            @(negedge clk);
        end
        repeat (DRAIN_CYCLES) @(negedge clk);
    endtask

    // --------------------
    // Output checks
    // --------------------
    // Mid-cycle sampling, all DUT outputs settled
    always @(negedge clk) begin
        reg_addr_t e_rd;
        word_t e_data;
        word_t e_addr;
        if (!arst_n) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] = fill_word(i);
            end
        end else begin
            if (wb.en) begin
                if (exp_rd.size() == 0) begin
                    $display("Unexpected register write x%0d = %h at %0t, none left to retire",
                             wb.addr, wb.data, $time);
                    other_errors++;
                end else begin
                    e_rd = exp_rd.pop_front();
                    e_data = exp_data.pop_front();
                    if (wb.addr != e_rd || wb.data != e_data) begin
                        $display("Mismatch at %0t: writeback expected x%0d = %h, got x%0d = %h",
                                 $time, e_rd, e_data, wb.addr, wb.data);
                        wb_errors++;
                    end
                end
            end
            if (dmem_req.read_en) begin
                if (exp_ld_addr.size() == 0) begin
                    $display("Unexpected load from %h at %0t, none left in the program",
                             dmem_req.addr, $time);
                    other_errors++;
                end else begin
                    e_addr = exp_ld_addr.pop_front();
                    if (dmem_req.addr != e_addr) begin
                        $display("Mismatch at %0t: load expected address %h, got %h",
                                 $time, e_addr, dmem_req.addr);
                        ld_errors++;
                    end
                end
            end
            if (dmem_req.write_en) begin
                if (exp_st_addr.size() == 0) begin
                    $display("Unexpected store to %h at %0t, none left in the program",
                             dmem_req.addr, $time);
                    other_errors++;
                end else begin
                    e_addr = exp_st_addr.pop_front();
                    e_data = exp_st_data.pop_front();
                    if (dmem_req.addr != e_addr || dmem_req.wdata != e_data) begin
                        $display("Mismatch at %0t: store expected [%h] = %h, got [%h] = %h",
                                 $time, e_addr, e_data, dmem_req.addr, dmem_req.wdata);
                        st_errors++;
                    end
                end
                // Write lands before the next rising edge
                dmem[dmem_req.addr[7:2]] = dmem_req.wdata;
            end
        end
    end

    // Run length guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run still busy after %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        seed = 70301;
        arst_n = 1'b0;
        wb_errors = 0;
        ld_errors = 0;
        st_errors = 0;
        other_errors = 0;
        for (int i = 0; i < 128; i++) begin
            imem[i] = NOP;
        end
        for (int p = 0; p < NUM_PROGS; p++) begin
            @(negedge clk);
            arst_n = 1'b0;
            gen_program();
            run_model();
            repeat (RESET_CYCLES) @(negedge clk);
            arst_n = 1'b1;
            wait_retire();
        end
        $display("Errors: writeback %0d, load %0d, store %0d, other %0d",
                 wb_errors, ld_errors, st_errors, other_errors);
        if (wb_errors + ld_errors + st_errors + other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
rtl/rv32i_pkg.sv
rtl/pipe_reg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/rv32i_core.sv
tests/tb_clock.sv
tests/rv32i_core_props.sv
tests/tb_rv32i_core.sv

// File: Bender.yml
package:
  name: rv32i_core

sources:
  - rtl/rv32i_pkg.sv
  - rtl/pipe_reg.sv
  - rtl/fetch_stage.sv
  - rtl/decode_stage.sv
  - rtl/hazard_unit.sv
  - rtl/execute_stage.sv
  - rtl/memory_stage.sv
  - rtl/rv32i_core.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/rv32i_core_props.sv
      - tests/tb_rv32i_core.sv
